//--- hdl/pager_pkg.sv
package pager_pkg;

	//////////////////////////////
	// address space geometry
	//////////////////////////////
	localparam int ZA_W      = 16;
	localparam int WIN_N     = 4;
	localparam int WIN_OFS_W = 14;
	localparam int PAGE_W    = 8;
	localparam int PHYS_W    = 22;

	// axi4-lite register side
	localparam int AXI_AW = 5;
	localparam int AXI_DW = 32;

	//////////////////////////////
	// register map
	//////////////////////////////
	localparam logic [AXI_AW-1:0] REG_PAGE0 = 5'h00;
	localparam logic [AXI_AW-1:0] REG_PAGE1 = 5'h04;
	localparam logic [AXI_AW-1:0] REG_PAGE2 = 5'h08;
	localparam logic [AXI_AW-1:0] REG_PAGE3 = 5'h0C;
	// rom select in 3..0, romrw_en in 4
	localparam logic [AXI_AW-1:0] REG_CTRL  = 5'h10;
	// read only, dos in bit 0
	localparam logic [AXI_AW-1:0] REG_STAT  = 5'h14;

	// window 0 starts as rom
	localparam logic [WIN_N-1:0] CTRL_RESET = 4'b0001;

	// opcode fetch from rom at 3Dxx pages the dos rom in
	localparam logic [7:0] DOS_HI = 8'h3D;

	localparam logic [1:0] RESP_OKAY   = 2'd0;
	localparam logic [1:0] RESP_SLVERR = 2'd2;

	//////////////////////////////
	// types
	//////////////////////////////
	typedef enum logic [1:0] {
		CYC_IDLE,
		CYC_FETCH,
		CYC_READ,
		CYC_WRITE
	} cyc_kind_e;

	typedef enum logic {
		RD_IDLE,
		RD_RESP
	} axi_rd_e;

	typedef enum logic {
		WR_IDLE,
		WR_RESP
	} axi_wr_e;

endpackage

//--- hdl/pager_regs.sv
module pager_regs (
	input  logic                             fclk,
	input  logic                             arst_n,
	// write address and data
	input  logic [pager_pkg::AXI_AW-1:0]     awaddr,
	input  logic                             awvalid,
	output logic                             awready,
	input  logic [pager_pkg::AXI_DW-1:0]     wdata,
	input  logic [pager_pkg::AXI_DW/8-1:0]   wstrb,
	input  logic                             wvalid,
	output logic                             wready,
	// write response
	output logic [1:0]                       bresp,
	output logic                             bvalid,
	input  logic                             bready,
	// read address and data
	input  logic [pager_pkg::AXI_AW-1:0]     araddr,
	input  logic                             arvalid,
	output logic                             arready,
	output logic [pager_pkg::AXI_DW-1:0]     rdata,
	output logic [1:0]                       rresp,
	output logic                             rvalid,
	input  logic                             rready,
	// status in, configuration out
	input  logic                             dos,
	output logic [pager_pkg::PAGE_W-1:0]     page0,
	output logic [pager_pkg::PAGE_W-1:0]     page1,
	output logic [pager_pkg::PAGE_W-1:0]     page2,
	output logic [pager_pkg::PAGE_W-1:0]     page3,
	output logic [pager_pkg::WIN_N-1:0]      romnram,
	output logic                             romrw_en
);
	pager_pkg::axi_wr_e              wr_state;
	pager_pkg::axi_rd_e              rd_state;
	logic                            wr_go;
	logic                            wr_hit;
	logic                            rd_go;
	logic                            rd_hit;
	logic [pager_pkg::AXI_DW-1:0]    rd_mux;

	//////////////////////////////
	// write channel
	//////////////////////////////
	// address and data taken in the same cycle
	assign wr_go   = (wr_state == pager_pkg::WR_IDLE) && awvalid && wvalid;
	assign awready = wr_go;
	assign wready  = wr_go;
	assign bvalid  = (wr_state == pager_pkg::WR_RESP);

	always_comb
	begin
		case (awaddr)
			pager_pkg::REG_PAGE0,
			pager_pkg::REG_PAGE1,
			pager_pkg::REG_PAGE2,
			pager_pkg::REG_PAGE3,
			pager_pkg::REG_CTRL: wr_hit = 1'b1;
			default:             wr_hit = 1'b0;
		endcase
	end

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			wr_state <= pager_pkg::WR_IDLE;
		else if (wr_go)
			wr_state <= pager_pkg::WR_RESP;
		else if (bvalid && bready)
			wr_state <= pager_pkg::WR_IDLE;
	end

	always_ff @(posedge fclk)
	begin
		if (wr_go)
			bresp <= wr_hit ? pager_pkg::RESP_OKAY : pager_pkg::RESP_SLVERR;
	end

	// only the low byte lane carries data
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			page0    <= '0;
			page1    <= '0;
			page2    <= '0;
			page3    <= '0;
			romnram  <= pager_pkg::CTRL_RESET;
			romrw_en <= 1'b0;
		end
		else if (wr_go && wr_hit && wstrb[0])
		begin
			case (awaddr)
				pager_pkg::REG_PAGE0: page0 <= wdata[pager_pkg::PAGE_W-1:0];
				pager_pkg::REG_PAGE1: page1 <= wdata[pager_pkg::PAGE_W-1:0];
				pager_pkg::REG_PAGE2: page2 <= wdata[pager_pkg::PAGE_W-1:0];
				pager_pkg::REG_PAGE3: page3 <= wdata[pager_pkg::PAGE_W-1:0];
				default:
				begin
					romnram  <= wdata[pager_pkg::WIN_N-1:0];
					romrw_en <= wdata[pager_pkg::WIN_N];
				end
			endcase
		end
	end

	//////////////////////////////
	// read channel
	//////////////////////////////
	assign rd_go   = (rd_state == pager_pkg::RD_IDLE) && arvalid;
	assign arready = rd_go;
	assign rvalid  = (rd_state == pager_pkg::RD_RESP);

	always_comb
	begin
		rd_mux = '0;
		rd_hit = 1'b1;
		case (araddr)
			pager_pkg::REG_PAGE0: rd_mux[pager_pkg::PAGE_W-1:0] = page0;
			pager_pkg::REG_PAGE1: rd_mux[pager_pkg::PAGE_W-1:0] = page1;
			pager_pkg::REG_PAGE2: rd_mux[pager_pkg::PAGE_W-1:0] = page2;
			pager_pkg::REG_PAGE3: rd_mux[pager_pkg::PAGE_W-1:0] = page3;
			pager_pkg::REG_CTRL:  rd_mux[pager_pkg::WIN_N:0]    = {romrw_en, romnram};
			pager_pkg::REG_STAT:  rd_mux[0]                     = dos;
			default:              rd_hit                        = 1'b0;
		endcase
	end

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			rd_state <= pager_pkg::RD_IDLE;
		else if (rd_go)
			rd_state <= pager_pkg::RD_RESP;
		else if (rvalid && rready)
			rd_state <= pager_pkg::RD_IDLE;
	end

	// data captured at the handshake, stable while rvalid waits
	always_ff @(posedge fclk)
	begin
		if (rd_go)
		begin
			rdata <= rd_mux;
			rresp <= rd_hit ? pager_pkg::RESP_OKAY : pager_pkg::RESP_SLVERR;
		end
	end

endmodule

//--- hdl/window_map.sv
module window_map (
	input  logic                             fclk,
	input  logic                             arst_n,
	// z80 bus, already in the fclk domain
	input  logic [pager_pkg::ZA_W-1:0]       a,
	input  logic                             mreq_n,
	input  logic                             m1_n,
	input  logic                             rd_n,
	input  logic                             wr_n,
	// configuration
	input  logic [pager_pkg::PAGE_W-1:0]     page0,
	input  logic [pager_pkg::PAGE_W-1:0]     page1,
	input  logic [pager_pkg::PAGE_W-1:0]     page2,
	input  logic [pager_pkg::PAGE_W-1:0]     page3,
	input  logic [pager_pkg::WIN_N-1:0]      romnram,
	input  logic                             romrw_en,
	input  logic                             dos,
	// translated cycle
	output logic [pager_pkg::PHYS_W-1:0]     phys_addr,
	output logic                             ram_req,
	output logic                             csrom,
	output logic                             romoe_n,
	output logic                             romwe_n,
	output pager_pkg::cyc_kind_e             cyc_kind,
	output logic                             map_rom,
	output logic [pager_pkg::ZA_W/2-1:0]     map_hi
);
	pager_pkg::cyc_kind_e                                 kind;
	logic [pager_pkg::ZA_W-pager_pkg::WIN_OFS_W-1:0]      win;
	logic [pager_pkg::PAGE_W-1:0]                         win_page;
	logic [pager_pkg::PAGE_W-1:0]                         phys_page;
	logic                                                 win_rom;
	logic                                                 access;

	//////////////////////////////
	// bus cycle decode
	//////////////////////////////
	always_comb
	begin
		if (mreq_n || (rd_n && wr_n))
			kind = pager_pkg::CYC_IDLE;
		else if (!m1_n && !rd_n)
			kind = pager_pkg::CYC_FETCH;
		else if (!rd_n)
			kind = pager_pkg::CYC_READ;
		else
			kind = pager_pkg::CYC_WRITE;
	end

	assign access = (kind != pager_pkg::CYC_IDLE);

	// window from the top address bits
	assign win = a[pager_pkg::ZA_W-1:pager_pkg::WIN_OFS_W];

	always_comb
	begin
		case (win)
			2'd0:    win_page = page0;
			2'd1:    win_page = page1;
			2'd2:    win_page = page2;
			default: win_page = page3;
		endcase
	end

	assign win_rom = romnram[win];

	// rom page bit 0 follows dos
	assign phys_page = win_rom ? {win_page[pager_pkg::PAGE_W-1:1], dos} : win_page;

	//////////////////////////////
	// output register
	//////////////////////////////
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			phys_addr <= '0;
			ram_req   <= 1'b0;
			csrom     <= 1'b0;
			romoe_n   <= 1'b1;
			romwe_n   <= 1'b1;
			cyc_kind  <= pager_pkg::CYC_IDLE;
			map_rom   <= 1'b0;
			map_hi    <= '0;
		end
		else
		begin
			phys_addr <= {phys_page, a[pager_pkg::WIN_OFS_W-1:0]};
			ram_req   <= access && !win_rom;
			csrom     <= access && win_rom;
			romoe_n   <= !(win_rom && (kind == pager_pkg::CYC_FETCH ||
				kind == pager_pkg::CYC_READ));
			// flash writes only once enabled
			romwe_n   <= !(win_rom && romrw_en && kind == pager_pkg::CYC_WRITE);
			cyc_kind  <= kind;
			map_rom   <= win_rom;
			map_hi    <= a[pager_pkg::ZA_W-1:pager_pkg::ZA_W/2];
		end
	end

endmodule

//--- hdl/dos_ctrl.sv
module dos_ctrl (
	input  logic                             fclk,
	input  logic                             arst_n,
	input  pager_pkg::cyc_kind_e             map_kind,
	input  logic                             map_rom,
	input  logic [pager_pkg::ZA_W/2-1:0]     map_hi,
	output logic                             dos
);
	logic is_fetch;
	logic dos_on;
	logic dos_off;

	//////////////////////////////
	// dos rom paging
	//////////////////////////////
	assign is_fetch = (map_kind == pager_pkg::CYC_FETCH);

	// entry point range of the disk rom
	assign dos_on  = is_fetch && map_rom && (map_hi == pager_pkg::DOS_HI);

	// any opcode from ram leaves dos
	assign dos_off = is_fetch && !map_rom;

	// long fetches just repeat the same decision
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			dos <= 1'b0;
		else if (dos_on)
			dos <= 1'b1;
		else if (dos_off)
			dos <= 1'b0;
	end

endmodule

//--- hdl/pager_top.sv
module pager_top (
	input  logic                             fclk,
	input  logic                             arst_n,
	// z80
	input  logic [pager_pkg::ZA_W-1:0]       a,
	input  logic                             mreq_n,
	input  logic                             m1_n,
	input  logic                             rd_n,
	input  logic                             wr_n,
	// axi4-lite configuration
	input  logic [pager_pkg::AXI_AW-1:0]     awaddr,
	input  logic                             awvalid,
	output logic                             awready,
	input  logic [pager_pkg::AXI_DW-1:0]     wdata,
	input  logic [pager_pkg::AXI_DW/8-1:0]   wstrb,
	input  logic                             wvalid,
	output logic                             wready,
	output logic [1:0]                       bresp,
	output logic                             bvalid,
	input  logic                             bready,
	input  logic [pager_pkg::AXI_AW-1:0]     araddr,
	input  logic                             arvalid,
	output logic                             arready,
	output logic [pager_pkg::AXI_DW-1:0]     rdata,
	output logic [1:0]                       rresp,
	output logic                             rvalid,
	input  logic                             rready,
	// memory side
	output logic [pager_pkg::PHYS_W-1:0]     phys_addr,
	output logic                             ram_req,
	output logic                             csrom,
	output logic                             romoe_n,
	output logic                             romwe_n,
	output pager_pkg::cyc_kind_e             cyc_kind
);
	logic [pager_pkg::PAGE_W-1:0]    page0;
	logic [pager_pkg::PAGE_W-1:0]    page1;
	logic [pager_pkg::PAGE_W-1:0]    page2;
	logic [pager_pkg::PAGE_W-1:0]    page3;
	logic [pager_pkg::WIN_N-1:0]     romnram;
	logic                            romrw_en;
	logic                            dos;
	logic                            map_rom;
	logic [pager_pkg::ZA_W/2-1:0]    map_hi;

	//////////////////////////////
	// configuration registers
	//////////////////////////////
	pager_regs u_regs (
		.fclk     (fclk),
		.arst_n   (arst_n),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wstrb    (wstrb),
		.wvalid   (wvalid),
		.wready   (wready),
		.bresp    (bresp),
		.bvalid   (bvalid),
		.bready   (bready),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready),
		.dos      (dos),
		.page0    (page0),
		.page1    (page1),
		.page2    (page2),
		.page3    (page3),
		.romnram  (romnram),
		.romrw_en (romrw_en)
	);

	//////////////////////////////
	// address translation
	//////////////////////////////
	window_map u_map (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.a         (a),
		.mreq_n    (mreq_n),
		.m1_n      (m1_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.page0     (page0),
		.page1     (page1),
		.page2     (page2),
		.page3     (page3),
		.romnram   (romnram),
		.romrw_en  (romrw_en),
		.dos       (dos),
		.phys_addr (phys_addr),
		.ram_req   (ram_req),
		.csrom     (csrom),
		.romoe_n   (romoe_n),
		.romwe_n   (romwe_n),
		.cyc_kind  (cyc_kind),
		.map_rom   (map_rom),
		.map_hi    (map_hi)
	);

	// dos follows the translated fetches
	dos_ctrl u_dos (
		.fclk     (fclk),
		.arst_n   (arst_n),
		.map_kind (cyc_kind),
		.map_rom  (map_rom),
		.map_hi   (map_hi),
		.dos      (dos)
	);

endmodule

//--- test/pager_chk.sv
module pager_chk (
	input logic       fclk,
	input logic       arst_n,
	input logic       romoe_n,
	input logic       romwe_n,
	input logic       ram_req,
	input logic       csrom,
	input logic       bvalid,
	input logic       bready,
	input logic [1:0] bresp,
	input logic       rvalid,
	input logic       rready,
	input logic [1:0] rresp
);
	int fail_cnt = 0;

	// rom is never read and written at once
	a_rom_strobes: assert property (@(posedge fclk) disable iff (!arst_n)
		!(!romoe_n && !romwe_n))
	else
	begin
		fail_cnt++;
		$error("romoe_n and romwe_n low together");
	end

	a_one_target: assert property (@(posedge fclk) disable iff (!arst_n)
		!(ram_req && csrom))
	else
	begin
		fail_cnt++;
		$error("ram_req and csrom high together");
	end

	// responses wait for the master
	a_b_hold: assert property (@(posedge fclk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else
	begin
		fail_cnt++;
		$error("bvalid or bresp changed before bready");
	end

	a_r_hold: assert property (@(posedge fclk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable(rresp))
	else
	begin
		fail_cnt++;
		$error("rvalid or rresp changed before rready");
	end

endmodule

bind pager_top pager_chk u_chk (
	.fclk    (fclk),
	.arst_n  (arst_n),
	.romoe_n (romoe_n),
	.romwe_n (romwe_n),
	.ram_req (ram_req),
	.csrom   (csrom),
	.bvalid  (bvalid),
	.bready  (bready),
	.bresp   (bresp),
	.rvalid  (rvalid),
	.rready  (rready),
	.rresp   (rresp)
);

//--- test/pager_tb.sv
module pager_tb;

	localparam int CYCLE_LIMIT = 6000;

	logic                              fclk;
	logic                              arst_n;
	logic [pager_pkg::ZA_W-1:0]        a;
	logic                              mreq_n;
	logic                              m1_n;
	logic                              rd_n;
	logic                              wr_n;
	logic [pager_pkg::AXI_AW-1:0]      awaddr;
	logic                              awvalid;
	logic                              awready;
	logic [pager_pkg::AXI_DW-1:0]      wdata;
	logic [pager_pkg::AXI_DW/8-1:0]    wstrb;
	logic                              wvalid;
	logic                              wready;
	logic [1:0]                        bresp;
	logic                              bvalid;
	logic                              bready;
	logic [pager_pkg::AXI_AW-1:0]      araddr;
	logic                              arvalid;
	logic                              arready;
	logic [pager_pkg::AXI_DW-1:0]      rdata;
	logic [1:0]                        rresp;
	logic                              rvalid;
	logic                              rready;
	logic [pager_pkg::PHYS_W-1:0]      phys_addr;
	logic                              ram_req;
	logic                              csrom;
	logic                              romoe_n;
	logic                              romwe_n;
	pager_pkg::cyc_kind_e              cyc_kind;

	// register and dos model
	logic [pager_pkg::PAGE_W-1:0]      m_page [pager_pkg::WIN_N];
	logic [pager_pkg::WIN_N-1:0]       m_rom;
	logic                              m_romrw;
	logic                              m_dos;

	// {hi byte, phys_addr, ram_req, csrom, romoe_n, romwe_n, kind}
	logic [35:0]                       exp_q [$];

	pager_top DUT (.*);

	initial
	begin
		fclk = 1'b0;
		forever #5 fclk = ~fclk;
	end

	//////////////////////////////
	// failure reporting
	//////////////////////////////
	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Some tests failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_addr(input logic [pager_pkg::PHYS_W-1:0] got,
		input logic [pager_pkg::PHYS_W-1:0] exp);
		if (got !== exp)
			stop_run($sformatf("Mismatch at %0t: phys_addr got %h expected %h", $time,
				got, exp));
	endtask

	task automatic check_kind(input pager_pkg::cyc_kind_e got,
		input pager_pkg::cyc_kind_e exp);
		if (got !== exp)
			stop_run($sformatf("Mismatch at %0t: cyc_kind got %s expected %s", $time,
				got.name(), exp.name()));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, what,
				got, exp));
	endtask

	task automatic check_resp(input logic [1:0] got_resp, input logic [1:0] exp_resp,
		input logic [pager_pkg::AXI_DW-1:0] got_data,
		input logic [pager_pkg::AXI_DW-1:0] exp_data,
		input string what);
		if (got_resp !== exp_resp || got_data !== exp_data)
			stop_run($sformatf("Mismatch at %0t: %s got %0d/%h expected %0d/%h", $time, what,
				got_resp, got_data, exp_resp, exp_data));
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////
	function automatic logic [35:0] ref_map(input logic [15:0] addr, input logic mreq,
		input logic m1, input logic rd, input logic wr);
		pager_pkg::cyc_kind_e kind;
		logic [pager_pkg::PAGE_W-1:0] page;
		logic rom;
		if (mreq || (rd && wr))
			kind = pager_pkg::CYC_IDLE;
		else if (!m1 && !rd)
			kind = pager_pkg::CYC_FETCH;
		else if (!rd)
			kind = pager_pkg::CYC_READ;
		else
			kind = pager_pkg::CYC_WRITE;
		page = m_page[addr[15:14]];
		rom = m_rom[addr[15:14]];
		if (rom)
			page[0] = m_dos;
		return {addr[15:8], page, addr[13:0],
			kind != pager_pkg::CYC_IDLE && !rom,
			kind != pager_pkg::CYC_IDLE && rom,
			!(rom && (kind == pager_pkg::CYC_FETCH || kind == pager_pkg::CYC_READ)),
			!(rom && m_romrw && kind == pager_pkg::CYC_WRITE),
			kind};
	endfunction

	// dos follows a fetch one cycle after its translation
	task automatic dos_step(input logic [35:0] v);
		if (v[1:0] == pager_pkg::CYC_FETCH)
		begin
			if (v[4] && v[35:28] == pager_pkg::DOS_HI)
				m_dos = 1'b1;
			else if (v[5])
				m_dos = 1'b0;
		end
	endtask

	initial
	begin : compare
		logic [35:0] exp_v;
		logic [35:0] prev_v;
		logic        prev_ok;
		prev_ok = 1'b0;
		@(posedge arst_n);
		exp_q.push_back(ref_map(a, mreq_n, m1_n, rd_n, wr_n));
		forever
		begin
			@(negedge fclk);
			if (prev_ok)
				dos_step(prev_v);
			exp_v = exp_q.pop_front();
			check_addr(phys_addr, exp_v[27:6]);
			check_bit(ram_req, exp_v[5], "ram_req");
			check_bit(csrom, exp_v[4], "csrom");
			check_bit(romoe_n, exp_v[3], "romoe_n");
			check_bit(romwe_n, exp_v[2], "romwe_n");
			check_kind(cyc_kind, pager_pkg::cyc_kind_e'(exp_v[1:0]));
			prev_v = exp_v;
			prev_ok = 1'b1;
			exp_q.push_back(ref_map(a, mreq_n, m1_n, rd_n, wr_n));
		end
	end

	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		forever
		begin
			@(posedge fclk);
			cycles++;
			if (DUT.u_chk.fail_cnt != 0)
				stop_run("An assertion in the bound checker failed");
			else if (cycles >= CYCLE_LIMIT)
				stop_run("Timeout: the run did not finish within the cycle limit");
		end
	end

	//////////////////////////////
	// bus tasks
	//////////////////////////////
	task automatic axi_write(input logic [pager_pkg::AXI_AW-1:0] addr,
		input logic [pager_pkg::AXI_DW-1:0] data, input logic [3:0] strb, input int stall);
		logic hit;
		hit = addr == pager_pkg::REG_PAGE0 || addr == pager_pkg::REG_PAGE1 ||
			addr == pager_pkg::REG_PAGE2 || addr == pager_pkg::REG_PAGE3 ||
			addr == pager_pkg::REG_CTRL;
		@(posedge fclk);
		awaddr <= addr;
		wdata <= data;
		wstrb <= strb;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do @(negedge fclk); while (!awready);
		check_bit(wready, 1'b1, "wready with awready");
		@(posedge fclk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		if (hit && strb[0])
		begin
			if (addr == pager_pkg::REG_CTRL)
				{m_romrw, m_rom} = data[4:0];
			else
				m_page[addr[3:2]] = data[7:0];
		end
		repeat (stall) @(posedge fclk);
		bready <= 1'b1;
		do @(negedge fclk); while (!bvalid);
		check_resp(bresp, hit ? pager_pkg::RESP_OKAY : pager_pkg::RESP_SLVERR,
			'0, '0, "bresp");
		@(posedge fclk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [pager_pkg::AXI_AW-1:0] addr, input int stall);
		logic [pager_pkg::AXI_DW-1:0] exp_data;
		logic [1:0]                   exp_resp;
		@(posedge fclk);
		araddr <= addr;
		arvalid <= 1'b1;
		do @(negedge fclk); while (!arready);
		@(posedge fclk);
		arvalid <= 1'b0;
		exp_data = '0;
		exp_resp = pager_pkg::RESP_OKAY;
		case (addr)
			pager_pkg::REG_PAGE0,
			pager_pkg::REG_PAGE1,
			pager_pkg::REG_PAGE2,
			pager_pkg::REG_PAGE3: exp_data[7:0] = m_page[addr[3:2]];
			pager_pkg::REG_CTRL:  exp_data[4:0] = {m_romrw, m_rom};
			pager_pkg::REG_STAT:  exp_data[0] = m_dos;
			default:              exp_resp = pager_pkg::RESP_SLVERR;
		endcase
		repeat (stall) @(posedge fclk);
		rready <= 1'b1;
		do @(negedge fclk); while (!rvalid);
		check_resp(rresp, exp_resp, rdata, exp_data, $sformatf("read of %h", addr));
		@(posedge fclk);
		rready <= 1'b0;
	endtask

	// one fclk per z80 cycle with an idle cycle after each fetch
	task automatic bus_cycle(input pager_pkg::cyc_kind_e kind, input logic [15:0] addr);
		@(posedge fclk);
		a <= addr;
		mreq_n <= (kind == pager_pkg::CYC_IDLE);
		m1_n <= (kind != pager_pkg::CYC_FETCH);
		rd_n <= !(kind == pager_pkg::CYC_FETCH || kind == pager_pkg::CYC_READ);
		wr_n <= (kind != pager_pkg::CYC_WRITE);
		if (kind == pager_pkg::CYC_FETCH)
		begin
			@(posedge fclk);
			mreq_n <= 1'b1;
			m1_n <= 1'b1;
			rd_n <= 1'b1;
		end
	endtask

	task automatic bus_random(input logic [15:0] addr);
		bus_cycle(pager_pkg::cyc_kind_e'(2'($urandom_range(0, 3))), addr);
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////
	initial
	begin : stimulus
		void'($urandom(17515));
		arst_n = 1'b0;
		a = '0;
		mreq_n = 1'b1;
		m1_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		for (int i = 0; i < pager_pkg::WIN_N; i++)
			m_page[i] = '0;
		m_rom = pager_pkg::CTRL_RESET;
		m_romrw = 1'b0;
		m_dos = 1'b0;
		repeat (10) @(posedge fclk);
		arst_n <= 1'b1;

		// reset values including unmapped offsets
		for (int i = 0; i < 8; i++)
			axi_read(5'(i * 4), 0);

		// configuration writes and readback
		for (int i = 0; i < 5; i++)
			axi_write(5'(i * 4), $urandom, 4'hF, 0);
		axi_write(pager_pkg::REG_PAGE1, $urandom, 4'hE, 0);
		axi_write(pager_pkg::REG_STAT, 32'h1, 4'hF, 0);
		axi_write(5'h18, $urandom, 4'hF, 0);
		axi_write(5'h02, $urandom, 4'hF, 0);
		for (int i = 0; i < 8; i++)
			axi_read(5'(i * 4), 0);

		// ram traffic over all windows
		axi_write(pager_pkg::REG_CTRL, 32'h0, 4'hF, 0);
		for (int n = 0; n < 8; n++)
		begin
			axi_write(5'($urandom_range(0, 3) * 4), $urandom, 4'hF, 0);
			repeat (50) bus_random(16'($urandom));
		end

		// rom everywhere with writes locked and then enabled
		axi_write(pager_pkg::REG_CTRL, 32'h0F, 4'hF, 0);
		repeat (100) bus_random(16'($urandom));
		axi_write(pager_pkg::REG_CTRL, 32'h1F, 4'hF, 0);
		repeat (100) bus_random(16'($urandom));

		// dos entry from the window 0 rom and exit from ram
		axi_write(pager_pkg::REG_CTRL, 32'h01, 4'hF, 0);
		axi_write(pager_pkg::REG_PAGE0, $urandom, 4'hF, 0);
		bus_cycle(pager_pkg::CYC_READ, 16'h0123);
		bus_cycle(pager_pkg::CYC_FETCH, {pager_pkg::DOS_HI, 8'($urandom)});
		bus_cycle(pager_pkg::CYC_READ, 16'h0123);
		axi_read(pager_pkg::REG_STAT, 0);
		bus_cycle(pager_pkg::CYC_FETCH, 16'hC000 | 16'($urandom_range(0, 16'h3FFF)));
		bus_cycle(pager_pkg::CYC_READ, 16'h0123);
		axi_read(pager_pkg::REG_STAT, 0);
		repeat (200)
			bus_random($urandom_range(0, 1) ? {pager_pkg::DOS_HI, 8'($urandom)} :
				16'($urandom));

		// back-pressure on both response channels
		repeat (40)
		begin
			if ($urandom_range(0, 1))
				axi_write(5'($urandom_range(0, 31)), $urandom, 4'($urandom),
					$urandom_range(0, 15));
			else
				axi_read(5'($urandom_range(0, 31)), $urandom_range(0, 15));
			bus_random(16'($urandom));
		end
		bus_cycle(pager_pkg::CYC_IDLE, 16'h0000);
		repeat (4) @(posedge fclk);

		if (DUT.u_chk.fail_cnt == 0)
		begin
			$display("All tests passed");
			$finish;
		end
		else
			stop_run("An assertion in the bound checker failed");
	end

endmodule

//--- list.f
hdl/pager_pkg.sv
hdl/pager_regs.sv
hdl/window_map.sv
hdl/dos_ctrl.sv
hdl/pager_top.sv
test/pager_chk.sv
test/pager_tb.sv
